/* core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// **************************************************
// Core-wide sizes and constants
// **************************************************

// Address of the first fetch after reset
`define RESET_PC 32'h0000_0000

// Architectural registers, x0 included
`define NUM_REGS 32

// Data and address width
`define XLEN 32

// Instruction width
`define ILEN 32

`endif

/* core_isa_pkg.sv */
`include "core_defines.svh"

package core_isa_pkg;

	// Data and address values
	typedef logic [`XLEN-1:0] word_t;

	// Raw instruction word
	typedef logic [`ILEN-1:0] inst_t;

	// Register index
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;

	// Major opcodes in use
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLL,
		SRL,
		COPY2, // operand 2 straight through, for LUI
		PC4    // link value
	} alu_fun_e;

	// Writeback source
	typedef enum logic [1:0] {
		NONE,
		ALU,
		MEM
	} wb_sel_e;

endpackage

/* core_pipe_pkg.sv */
package core_pipe_pkg;

	// **************************************************
	// Fetch to decode
	// **************************************************
	typedef struct packed {
		logic                valid;
		core_isa_pkg::word_t pc;
		core_isa_pkg::inst_t inst;
	} fetch_to_decode_t;

	// **************************************************
	// Decode to execute
	// **************************************************
	typedef struct packed {
		logic                   valid;
		core_isa_pkg::word_t    pc;
		core_isa_pkg::alu_fun_e alu_fun;
		core_isa_pkg::word_t    op1;
		core_isa_pkg::word_t    op2;
		core_isa_pkg::word_t    rs2_data;
		// B immediate, or the J immediate for JAL
		core_isa_pkg::word_t    imm_b;
		logic                   mem_wen;
		logic                   mem_ren;
		core_isa_pkg::wb_sel_e  wb_sel;
		core_isa_pkg::reg_addr_t rd;
		logic                   is_branch;
		logic                   branch_ne;
		logic                   is_jal;
	} decode_to_execute_t;

	// **************************************************
	// Execute to result
	// **************************************************
	typedef struct packed {
		logic                    valid;
		core_isa_pkg::word_t     alu_out;
		core_isa_pkg::word_t     rs2_data;
		logic                    mem_wen;
		logic                    mem_ren;
		core_isa_pkg::wb_sel_e   wb_sel;
		core_isa_pkg::reg_addr_t rd;
	} execute_to_result_t;

	// Register write, doubles as the commit trace
	typedef struct packed {
		logic                    valid;
		core_isa_pkg::reg_addr_t rd;
		core_isa_pkg::word_t     data;
	} retire_t;

endpackage

/* core_pipeline.sv */
`timescale 1ns/1ps

module core_pipeline (
	input  logic                    clk,
	input  logic                    rst,
	output core_isa_pkg::word_t     i_addr,
	input  core_isa_pkg::word_t     inst,
	output core_isa_pkg::word_t     d_addr,
	output core_isa_pkg::word_t     d_wdata,
	output logic                    d_wen,
	output logic                    d_ren,
	input  core_isa_pkg::word_t     d_rdata,
	output logic                    retire_valid,
	output core_isa_pkg::reg_addr_t retire_rd,
	output core_isa_pkg::word_t     retire_data
);

	core_pipe_pkg::fetch_to_decode_t f2d;
	core_pipe_pkg::decode_to_execute_t d2e;
	core_pipe_pkg::execute_to_result_t e2r;
	core_pipe_pkg::retire_t wb;
	logic stall;
	logic redirect;
	core_isa_pkg::word_t redirect_pc;
	core_isa_pkg::reg_addr_t rs1_addr;
	core_isa_pkg::reg_addr_t rs2_addr;
	core_isa_pkg::word_t rs1_data;
	core_isa_pkg::word_t rs2_data;

	// **************************************************
	// Fetch and decode
	// **************************************************
	fetch_stage u_fetch (
		.clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
		.redirect_pc(redirect_pc), .i_addr(i_addr), .inst(inst), .to_decode(f2d)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst), .from_fetch(f2d), .flush(redirect),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.ex_hazard(e2r), .stall(stall), .to_execute(d2e)
	);

	register_file u_regs (
		.clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data), .wb(wb)
	);

	// **************************************************
	// Execute and result
	// **************************************************
	execute_stage u_execute (
		.clk(clk), .rst(rst), .from_decode(d2e), .redirect(redirect),
		.redirect_pc(redirect_pc), .to_result(e2r)
	);

	result_stage u_result (
		.clk(clk), .rst(rst), .from_execute(e2r), .d_addr(d_addr),
		.d_wdata(d_wdata), .d_wen(d_wen), .d_ren(d_ren), .d_rdata(d_rdata), .wb(wb)
	);

	// Commit trace
	assign retire_valid = wb.valid;
	assign retire_rd = wb.rd;
	assign retire_data = wb.data;

endmodule

/* core_pipeline_checker.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module core_pipeline_checker (
	input logic        clk,
	input logic        rst,
	input logic [31:0] i_addr,
	input logic        d_wen,
	input logic        d_ren,
	input logic        retire_valid,
	input logic [4:0]  retire_rd
);

	// x0 is never a retire target
	retire_not_x0: assert property (@(posedge clk) disable iff (rst)
		retire_valid |-> retire_rd != 5'd0)
		else $error("retire reported for x0");

	mem_strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(d_wen && d_ren))
		else $error("d_wen and d_ren high together");

	fetch_aligned: assert property (@(posedge clk) disable iff (rst)
		i_addr[1:0] == 2'b00)
		else $error("i_addr not word aligned");

	// Quiet in the cycle after a reset edge
	quiet_after_reset: assert property (@(posedge clk)
		rst |=> (!d_wen && !d_ren && !retire_valid && i_addr == `RESET_PC))
		else $error("core not quiet after reset");

endmodule

bind core_pipeline core_pipeline_checker u_checker (
	.clk(clk),
	.rst(rst),
	.i_addr(i_addr),
	.d_wen(d_wen),
	.d_ren(d_ren),
	.retire_valid(retire_valid),
	.retire_rd(retire_rd)
);

/* core_pipeline_tb.sv */
`timescale 1ns/1ps

module core_pipeline_tb;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	localparam int F3_ADD = 0;
	localparam int F3_SLL = 1;
	localparam int F3_SLT = 2;
	localparam int F3_XOR = 4;
	localparam int F3_SRL = 5;
	localparam int F3_OR = 6;
	localparam int F3_AND = 7;
	localparam int F3_BEQ = 0;
	localparam int F3_BNE = 1;
	localparam int F7_SUB = 32;

	localparam int ROM_WORDS = 64;
	localparam int RAM_WORDS = 64;
	localparam logic [31:0] ROM_BYTES = 32'd256;
	localparam int CYCLES_PER_INST = 40;
	// ADDI x0, x0, 0
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic clk;
	logic rst;
	logic [31:0] i_addr;
	logic [31:0] inst;
	logic [31:0] d_addr;
	logic [31:0] d_wdata;
	logic d_wen;
	logic d_ren;
	logic [31:0] d_rdata;
	logic retire_valid;
	logic [4:0] retire_rd;
	logic [31:0] retire_data;

	logic [31:0] rom [ROM_WORDS];
	logic [31:0] ram [RAM_WORDS];
	logic [31:0] fill [RAM_WORDS];

	// **************************************************
	// Test table, one program and retire list per test
	// **************************************************
	string test_name [$];
	int prog_first [$];
	int exp_first [$];
	logic [31:0] prog_word [$];
	logic [4:0] exp_rd [$];
	logic [31:0] exp_data [$];

	int cycle_count = 0;
	int cycle_limit = 0;
	int errors = 0;
	int failed_tests = 0;
	int got_n;
	int exp_base;
	int exp_n;
	logic collecting;

	core_pipeline dut (
		.clk(clk), .rst(rst), .i_addr(i_addr), .inst(inst), .d_addr(d_addr),
		.d_wdata(d_wdata), .d_wen(d_wen), .d_ren(d_ren), .d_rdata(d_rdata),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
	);

	function automatic logic [31:0] reg_alu(input int f3, input int f7, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
	endfunction

	function automatic logic [31:0] imm_alu(input int f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] upper_imm(input int rd, input int imm);
		return {imm[19:0], rd[4:0], OPC_LUI};
	endfunction

	function automatic logic [31:0] load_word(input int rd, input int rs1, input int off);
		return {off[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
	endfunction

	function automatic logic [31:0] store_word(input int rs2, input int rs1, input int off);
		return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] branch_inst(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] jump_link(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	task automatic new_test(input string name);
		test_name.push_back(name);
		prog_first.push_back(prog_word.size());
		exp_first.push_back(exp_rd.size());
	endtask

	// Instruction that never retires
	task automatic append_inst(input logic [31:0] word);
		prog_word.push_back(word);
	endtask

	// Instruction with its expected retire, in program order
	task automatic append_writer(input logic [31:0] word, input int rd, input logic [31:0] data);
		prog_word.push_back(word);
		exp_rd.push_back(rd[4:0]);
		exp_data.push_back(data);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic build_table();
		new_test("register ALU ops");
		append_writer(imm_alu(F3_ADD, 1, 0, 25), 1, 32'h0000_0019);
		append_writer(imm_alu(F3_ADD, 2, 0, -6), 2, 32'hffff_fffa);
		append_writer(reg_alu(F3_ADD, 0, 3, 1, 2), 3, 32'h0000_0013);
		append_writer(reg_alu(F3_ADD, F7_SUB, 4, 1, 2), 4, 32'h0000_001f);
		append_writer(reg_alu(F3_AND, 0, 5, 1, 2), 5, 32'h0000_0018);
		append_writer(reg_alu(F3_OR, 0, 6, 1, 2), 6, 32'hffff_fffb);
		append_writer(reg_alu(F3_XOR, 0, 7, 1, 2), 7, 32'hffff_ffe3);
		append_writer(reg_alu(F3_SLT, 0, 8, 2, 1), 8, 32'h0000_0001);
		append_writer(reg_alu(F3_SLT, 0, 9, 1, 2), 9, 32'h0000_0000);
		append_writer(reg_alu(F3_SLL, 0, 10, 1, 2), 10, 32'h6400_0000);
		append_writer(reg_alu(F3_SRL, 0, 11, 2, 1), 11, 32'h0000_007f);

		new_test("LUI and immediate ops");
		append_writer(upper_imm(1, 'h12345), 1, 32'h1234_5000);
		append_writer(imm_alu(F3_ADD, 2, 1, -1), 2, 32'h1234_4fff);
		append_writer(imm_alu(F3_XOR, 3, 0, -1), 3, 32'hffff_ffff);
		append_writer(imm_alu(F3_OR, 4, 0, 'h7ff), 4, 32'h0000_07ff);
		append_writer(imm_alu(F3_AND, 5, 3, 'h0f0), 5, 32'h0000_00f0);
		append_writer(imm_alu(F3_SLT, 6, 3, 1), 6, 32'h0000_0001);
		append_writer(imm_alu(F3_SLL, 7, 4, 4), 7, 32'h0000_7ff0);
		append_writer(imm_alu(F3_SRL, 8, 3, 28), 8, 32'h0000_000f);

		// Every instruction reads the previous result
		new_test("dependent chain");
		append_writer(imm_alu(F3_ADD, 1, 0, 1), 1, 32'h1);
		append_writer(reg_alu(F3_ADD, 0, 1, 1, 1), 1, 32'h2);
		append_writer(reg_alu(F3_ADD, 0, 1, 1, 1), 1, 32'h4);
		append_writer(imm_alu(F3_ADD, 2, 1, 3), 2, 32'h7);
		append_writer(reg_alu(F3_ADD, F7_SUB, 3, 2, 1), 3, 32'h3);
		append_writer(reg_alu(F3_SLL, 0, 4, 2, 3), 4, 32'h38);

		new_test("store and load");
		append_writer(imm_alu(F3_ADD, 1, 0, 'h40), 1, 32'h40);
		append_writer(upper_imm(2, 'habcde), 2, 32'habcd_e000);
		append_writer(imm_alu(F3_ADD, 2, 2, 'h123), 2, 32'habcd_e123);
		append_inst(store_word(2, 1, 4));
		append_writer(load_word(3, 1, 4), 3, 32'habcd_e123);
		append_writer(load_word(4, 0, 8), 4, fill[2]);
		append_writer(load_word(5, 1, 0), 5, fill[16]);

		// Taken BEQ at 8 lands on 20, BNE at 28 on 36, JAL at 36 on 48
		new_test("branches and jump");
		append_writer(imm_alu(F3_ADD, 1, 0, 5), 1, 32'h5);
		append_writer(imm_alu(F3_ADD, 2, 0, 5), 2, 32'h5);
		append_inst(branch_inst(F3_BEQ, 1, 2, 12));
		append_inst(imm_alu(F3_ADD, 3, 0, 1));
		append_inst(imm_alu(F3_ADD, 3, 0, 2));
		append_inst(branch_inst(F3_BNE, 1, 2, 8));
		append_writer(imm_alu(F3_ADD, 4, 0, 3), 4, 32'h3);
		append_inst(branch_inst(F3_BNE, 1, 0, 8));
		append_inst(imm_alu(F3_ADD, 5, 0, 9));
		append_writer(jump_link(6, 12), 6, 32'h28);
		append_inst(imm_alu(F3_ADD, 7, 0, 1));
		append_inst(imm_alu(F3_ADD, 7, 0, 2));
		append_writer(imm_alu(F3_ADD, 8, 6, 1), 8, 32'h29);

		new_test("x0 writes");
		append_inst(imm_alu(F3_ADD, 0, 0, 7));
		append_writer(reg_alu(F3_ADD, 0, 1, 0, 0), 1, 32'h0);
		append_inst(upper_imm(0, 'hfffff));
		append_writer(imm_alu(F3_ADD, 2, 0, 12), 2, 32'hc);
		append_writer(reg_alu(F3_OR, 0, 3, 0, 2), 3, 32'hc);
	endtask

	// **************************************************
	// One clock: drive at the falling edge, sample 1 ns later
	// **************************************************
	task automatic clock_cycle(input logic reset_level);
		@(negedge clk);
		rst = reset_level;
		inst = (i_addr < ROM_BYTES) ? rom[i_addr[7:2]] : NOP;
		d_rdata = d_ren ? ram[d_addr[7:2]] : 32'h0;
		#1;
		// Store commits at the end of its cycle
		if (d_wen) begin
			ram[d_addr[7:2]] = d_wdata;
		end
		if (collecting && retire_valid) begin
			if (got_n < exp_n) begin
				check_value("retire_rd", {27'b0, retire_rd}, {27'b0, exp_rd[exp_base + got_n]});
				check_value("retire_data", retire_data, exp_data[exp_base + got_n]);
			end
			got_n++;
		end
	endtask

	task automatic run_test(input int t);
		int prog_end;
		int exp_end;
		int errors_before;
		prog_end = (t + 1 < test_name.size()) ? prog_first[t + 1] : prog_word.size();
		exp_end = (t + 1 < test_name.size()) ? exp_first[t + 1] : exp_rd.size();
		exp_base = exp_first[t];
		exp_n = exp_end - exp_base;
		errors_before = errors;
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = NOP;
		end
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram[i] = fill[i];
		end
		for (int i = prog_first[t]; i < prog_end; i++) begin
			rom[i - prog_first[t]] = prog_word[i];
		end
		repeat (4) begin
			clock_cycle(1'b1);
		end
		got_n = 0;
		collecting = 1'b1;
		while (got_n < exp_n) begin
			clock_cycle(1'b0);
		end
		// Wrong-path slots and the trailing NOPs stay silent
		repeat (8) begin
			clock_cycle(1'b0);
		end
		collecting = 1'b0;
		check_value("retire count", got_n, exp_n);
		if (errors != errors_before) begin
			failed_tests++;
		end
		$display("Test %0d (%s): %0d retires, %s", t, test_name[t], got_n,
			(errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the core stopped retiring", cycle_count);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		inst = NOP;
		d_rdata = 32'h0;
		collecting = 1'b0;
		void'($urandom(32'hdd20));
		for (int i = 0; i < RAM_WORDS; i++) begin
			fill[i] = $urandom();
		end
		build_table();
		cycle_limit = CYCLES_PER_INST * prog_word.size();
		for (int t = 0; t < test_name.size(); t++) begin
			run_test(t);
		end
		$display("Summary: %0d tests, %0d failed, %0d errors", test_name.size(),
			failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic                              clk,
	input  logic                              rst,
	input  core_pipe_pkg::fetch_to_decode_t   from_fetch,
	input  logic                              flush,
	output core_isa_pkg::reg_addr_t           rs1_addr,
	output core_isa_pkg::reg_addr_t           rs2_addr,
	input  core_isa_pkg::word_t               rs1_data,
	input  core_isa_pkg::word_t               rs2_data,
	input  core_pipe_pkg::execute_to_result_t ex_hazard,
	output logic                              stall,
	output core_pipe_pkg::decode_to_execute_t to_execute
);

	core_isa_pkg::inst_t inst;
	core_isa_pkg::opcode_e opcode;
	logic [2:0] funct3;
	core_isa_pkg::reg_addr_t rd;
	core_isa_pkg::word_t imm_i;
	core_isa_pkg::word_t imm_s;
	core_isa_pkg::word_t imm_b;
	core_isa_pkg::word_t imm_j;
	core_isa_pkg::word_t imm_u;
	logic use_rs1;
	logic use_rs2;
	logic hazard_ex;
	logic hazard_res;
	core_pipe_pkg::decode_to_execute_t next;

	function automatic core_isa_pkg::alu_fun_e alu_from_funct3(input logic [2:0] f3,
		input logic sub);
		case (f3)
			3'b000: return sub ? core_isa_pkg::SUB : core_isa_pkg::ADD;
			3'b111: return core_isa_pkg::AND;
			3'b110: return core_isa_pkg::OR;
			3'b100: return core_isa_pkg::XOR;
			3'b010: return core_isa_pkg::SLT;
			3'b001: return core_isa_pkg::SLL;
			default: return core_isa_pkg::SRL;
		endcase
	endfunction

	// True when src is read and a pending writer targets it
	function automatic logic raw_match(input logic used, input core_isa_pkg::reg_addr_t src,
		input logic valid, input core_isa_pkg::wb_sel_e wb_sel,
		input core_isa_pkg::reg_addr_t dst);
		return used && (src != '0) && valid && (wb_sel != core_isa_pkg::NONE) && (dst == src);
	endfunction

	// **************************************************
	// Fields and immediates
	// **************************************************
	assign inst = from_fetch.inst;
	assign opcode = core_isa_pkg::opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign rd = inst[11:7];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};

	// **************************************************
	// Hazard detection, no forwarding
	// **************************************************
	assign use_rs1 = opcode inside {core_isa_pkg::OP, core_isa_pkg::OP_IMM,
		core_isa_pkg::LOAD, core_isa_pkg::STORE, core_isa_pkg::BRANCH};
	assign use_rs2 = opcode inside {core_isa_pkg::OP, core_isa_pkg::STORE,
		core_isa_pkg::BRANCH};

	// Writer now in execute
	assign hazard_ex = raw_match(use_rs1, rs1_addr, to_execute.valid, to_execute.wb_sel,
		to_execute.rd) || raw_match(use_rs2, rs2_addr, to_execute.valid,
		to_execute.wb_sel, to_execute.rd);
	// Writer now in result
	assign hazard_res = raw_match(use_rs1, rs1_addr, ex_hazard.valid, ex_hazard.wb_sel,
		ex_hazard.rd) || raw_match(use_rs2, rs2_addr, ex_hazard.valid,
		ex_hazard.wb_sel, ex_hazard.rd);

	assign stall = from_fetch.valid & (hazard_ex | hazard_res);

	// **************************************************
	// Control decode
	// **************************************************
	always_comb begin
		next = '0;
		next.valid = from_fetch.valid & ~stall & ~flush;
		next.pc = from_fetch.pc;
		next.op1 = rs1_data;
		next.op2 = rs2_data;
		next.rs2_data = rs2_data;
		next.rd = rd;
		next.imm_b = imm_b;
		next.alu_fun = core_isa_pkg::ADD;
		next.wb_sel = core_isa_pkg::NONE;
		case (opcode)
			core_isa_pkg::OP: begin
				next.alu_fun = alu_from_funct3(funct3, inst[30]);
				next.wb_sel = core_isa_pkg::ALU;
			end
			core_isa_pkg::OP_IMM: begin
				next.alu_fun = alu_from_funct3(funct3, 1'b0);
				next.op2 = imm_i;
				next.wb_sel = core_isa_pkg::ALU;
			end
			core_isa_pkg::LUI: begin
				next.alu_fun = core_isa_pkg::COPY2;
				next.op2 = imm_u;
				next.wb_sel = core_isa_pkg::ALU;
			end
			core_isa_pkg::LOAD: begin
				next.op2 = imm_i;
				next.mem_ren = 1'b1;
				next.wb_sel = core_isa_pkg::MEM;
			end
			core_isa_pkg::STORE: begin
				next.op2 = imm_s;
				next.mem_wen = 1'b1;
			end
			core_isa_pkg::BRANCH: begin
				next.is_branch = 1'b1;
				// BNE differs from BEQ only in funct3 bit 0
				next.branch_ne = funct3[0];
			end
			core_isa_pkg::JAL: begin
				next.alu_fun = core_isa_pkg::PC4;
				next.imm_b = imm_j;
				next.is_jal = 1'b1;
				next.wb_sel = core_isa_pkg::ALU;
			end
			default: begin
				// Unknown opcodes run as a NOP
				next.rd = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		to_execute <= next;
		if (rst) begin
			to_execute.valid <= 1'b0;
		end
	end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic                              clk,
	input  logic                              rst,
	input  core_pipe_pkg::decode_to_execute_t from_decode,
	output logic                              redirect,
	output core_isa_pkg::word_t               redirect_pc,
	output core_pipe_pkg::execute_to_result_t to_result
);

	core_isa_pkg::word_t alu_out;
	logic taken;
	core_pipe_pkg::execute_to_result_t next;

	// **************************************************
	// ALU
	// **************************************************
	always_comb begin
		case (from_decode.alu_fun)
			core_isa_pkg::ADD: alu_out = from_decode.op1 + from_decode.op2;
			core_isa_pkg::SUB: alu_out = from_decode.op1 - from_decode.op2;
			core_isa_pkg::AND: alu_out = from_decode.op1 & from_decode.op2;
			core_isa_pkg::OR: alu_out = from_decode.op1 | from_decode.op2;
			core_isa_pkg::XOR: alu_out = from_decode.op1 ^ from_decode.op2;
			core_isa_pkg::SLT: begin
				alu_out = ($signed(from_decode.op1) < $signed(from_decode.op2)) ? 32'd1 : 32'd0;
			end
			core_isa_pkg::SLL: alu_out = from_decode.op1 << from_decode.op2[4:0];
			core_isa_pkg::SRL: alu_out = from_decode.op1 >> from_decode.op2[4:0];
			core_isa_pkg::COPY2: alu_out = from_decode.op2;
			core_isa_pkg::PC4: alu_out = from_decode.pc + 32'd4;
			default: alu_out = '0;
		endcase
	end

	// **************************************************
	// Branch and jump
	// **************************************************
	assign taken = from_decode.is_branch &
		((from_decode.op1 == from_decode.op2) ^ from_decode.branch_ne);

	// Also serves as the flush of decode
	assign redirect = from_decode.valid & (taken | from_decode.is_jal);
	assign redirect_pc = from_decode.pc + from_decode.imm_b;

	always_comb begin
		next.valid = from_decode.valid;
		next.alu_out = alu_out;
		next.rs2_data = from_decode.rs2_data;
		next.mem_wen = from_decode.mem_wen;
		next.mem_ren = from_decode.mem_ren;
		next.wb_sel = from_decode.wb_sel;
		next.rd = from_decode.rd;
	end

	always_ff @(posedge clk) begin
		to_result <= next;
		if (rst) begin
			to_result.valid <= 1'b0;
		end
	end

endmodule

/* fetch_stage.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_stage (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            stall,
	input  logic                            redirect,
	input  core_isa_pkg::word_t             redirect_pc,
	output core_isa_pkg::word_t             i_addr,
	input  core_isa_pkg::word_t             inst,
	output core_pipe_pkg::fetch_to_decode_t to_decode
);

	core_isa_pkg::word_t pc;

	// Memory answers in the same cycle
	assign i_addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
			to_decode.valid <= 1'b0;
		end else if (redirect) begin
			// Redirect wins over stall, wrong-path slot dropped
			pc <= redirect_pc;
			to_decode.valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + 32'd4;
			to_decode.valid <= 1'b1;
			to_decode.pc <= pc;
			to_decode.inst <= inst;
		end
	end

endmodule

/* register_file.sv */
`timescale 1ns/1ps
`include "core_defines.svh"

module register_file (
	input  logic                    clk,
	input  logic                    rst,
	input  core_isa_pkg::reg_addr_t rs1_addr,
	input  core_isa_pkg::reg_addr_t rs2_addr,
	output core_isa_pkg::word_t     rs1_data,
	output core_isa_pkg::word_t     rs2_data,
	input  core_pipe_pkg::retire_t  wb
);

	// x0 has no storage
	core_isa_pkg::word_t regs [1:`NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// Same-cycle write is visible on the read ports
	assign rs1_data = (rs1_addr == '0) ? '0 :
		(wb.valid && wb.rd == rs1_addr) ? wb.data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 :
		(wb.valid && wb.rd == rs2_addr) ? wb.data : regs[rs2_addr];

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage (
	input  logic                              clk,
	input  logic                              rst,
	input  core_pipe_pkg::execute_to_result_t from_execute,
	output core_isa_pkg::word_t               d_addr,
	output core_isa_pkg::word_t               d_wdata,
	output logic                              d_wen,
	output logic                              d_ren,
	input  core_isa_pkg::word_t               d_rdata,
	output core_pipe_pkg::retire_t            wb
);

	// Low until the first edge out of reset
	logic active;
	logic live;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
		end else begin
			active <= 1'b1;
		end
	end

	assign live = active & from_execute.valid;

	// Data memory, address from the ALU
	assign d_addr = from_execute.alu_out;
	assign d_wdata = from_execute.rs2_data;
	assign d_wen = live & from_execute.mem_wen;
	assign d_ren = live & from_execute.mem_ren;

	// Writeback and commit trace
	always_comb begin
		wb.rd = from_execute.rd;
		wb.valid = live && (from_execute.rd != '0) &&
			(from_execute.wb_sel != core_isa_pkg::NONE);
		case (from_execute.wb_sel)
			core_isa_pkg::MEM: wb.data = d_rdata;
			default: wb.data = from_execute.alu_out;
		endcase
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
	--top-module core_pipeline_tb -o sim_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1

/* src.f */
+incdir+.
core_isa_pkg.sv
core_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
result_stage.sv
core_pipeline.sv
core_pipeline_checker.sv
core_pipeline_tb.sv
